//--- rtl/rv_pkg.sv
// shared widths, rv32i encodings and selector codes; only the rv32i subset the core runs
package rv_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths and reset
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int xlen = 32;
  localparam int reg_aw = 5;

  // first fetch address
  localparam logic [xlen-1:0] pc_reset = 32'h8000_0000;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcodes and function codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // only meaningful with op_reg and f3_add
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // selector codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_xor,
    alu_or,
    alu_and,
    // forwards operand b, used by lui
    alu_passb
  } alu_op_t;

  typedef enum logic [2:0] {
    imm_i,
    imm_u,
    imm_j,
    imm_none
  } imm_sel_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_pc4
  } wb_sel_t;

endpackage

//--- rtl/key_mux.sv
// combinational lookup; several matching keys give the OR of their values
module key_mux #(
  parameter int nr_key = 2,
  parameter int key_len = 1,
  parameter type data_t = logic
) (
  input  logic [key_len-1:0]             key,
  input  logic [nr_key-1:0][key_len-1:0] keys,
  input  data_t                          values [nr_key],
  input  data_t                          default_value,
  output data_t                          value,
  output logic                           hit
);

  logic [$bits(data_t)-1:0] match_or;

  always_comb begin
    match_or = '0;
    hit = 1'b0;
    for (int i = 0; i < nr_key; i++) begin
      if (key == keys[i]) begin
        match_or = match_or | values[i];
        hit = 1'b1;
      end
    end
  end

  assign value = hit ? data_t'(match_or) : default_value;

endmodule

//--- rtl/pc_fetch.sv
// program counter; fetch memory must return the word at pc in the same cycle
module pc_fetch (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic                    is_jal,
  input  logic                    stop,
  input  logic                    halt,
  output logic [rv_pkg::xlen-1:0] pc
);

  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] jump_target;
  logic [rv_pkg::xlen-1:0] pc_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next pc
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign pc_plus4 = pc + 32'd4;

  // jal target is relative to the jal itself
  assign jump_target = pc + imm;

  assign pc_next = is_jal ? jump_target : pc_plus4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pc register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pkg::pc_reset;
    end else if (!stop && !halt) begin
      pc <= pc_next;
    end
  end

  // a halting instruction keeps pc on itself, and halt keeps it there

endmodule

//--- rtl/inst_decode.sv
// decodes the rv32i subset only; other funct3 under op_imm or op_reg counts as illegal
module inst_decode (
  input  logic [rv_pkg::xlen-1:0]   inst,
  output logic [rv_pkg::reg_aw-1:0] rs1,
  output logic [rv_pkg::reg_aw-1:0] rs2,
  output logic [rv_pkg::reg_aw-1:0] rd,
  output logic [rv_pkg::xlen-1:0]   imm,
  output rv_pkg::alu_op_t           alu_op,
  output rv_pkg::wb_sel_t           wb_sel,
  output logic                      src_a_pc,
  output logic                      src_b_imm,
  output logic                      reg_we,
  output logic                      is_jal,
  output logic                      is_ebreak,
  output logic                      is_illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  logic [5:0][6:0]  op_keys;
  rv_pkg::imm_sel_t op_vals [6];
  rv_pkg::imm_sel_t imm_sel;
  logic             op_hit;

  logic [4:0][2:0]  f3_keys;
  rv_pkg::alu_op_t  f3_vals [5];
  rv_pkg::alu_op_t  f3_op;
  logic             f3_hit;

  logic is_arith;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcode table, picks the immediate format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    op_keys[0] = rv_pkg::op_imm;
    op_vals[0] = rv_pkg::imm_i;
    op_keys[1] = rv_pkg::op_reg;
    op_vals[1] = rv_pkg::imm_none;
    op_keys[2] = rv_pkg::op_lui;
    op_vals[2] = rv_pkg::imm_u;
    op_keys[3] = rv_pkg::op_auipc;
    op_vals[3] = rv_pkg::imm_u;
    op_keys[4] = rv_pkg::op_jal;
    op_vals[4] = rv_pkg::imm_j;
    op_keys[5] = rv_pkg::op_system;
    op_vals[5] = rv_pkg::imm_none;
  end

  key_mux #(
    .nr_key (6),
    .key_len(7),
    .data_t (rv_pkg::imm_sel_t)
  ) op_mux_inst (
    .key          (opcode),
    .keys         (op_keys),
    .values       (op_vals),
    .default_value(rv_pkg::imm_none),
    .value        (imm_sel),
    .hit          (op_hit)
  );

  // funct3 table for op_imm and op_reg
  always_comb begin
    f3_keys[0] = rv_pkg::f3_add;
    f3_vals[0] = rv_pkg::alu_add;
    f3_keys[1] = rv_pkg::f3_slt;
    f3_vals[1] = rv_pkg::alu_slt;
    f3_keys[2] = rv_pkg::f3_xor;
    f3_vals[2] = rv_pkg::alu_xor;
    f3_keys[3] = rv_pkg::f3_or;
    f3_vals[3] = rv_pkg::alu_or;
    f3_keys[4] = rv_pkg::f3_and;
    f3_vals[4] = rv_pkg::alu_and;
  end

  key_mux #(
    .nr_key (5),
    .key_len(3),
    .data_t (rv_pkg::alu_op_t)
  ) f3_mux_inst (
    .key          (funct3),
    .keys         (f3_keys),
    .values       (f3_vals),
    .default_value(rv_pkg::alu_add),
    .value        (f3_op),
    .hit          (f3_hit)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // immediate and control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (imm_sel)
      rv_pkg::imm_i: imm = {{20{inst[31]}}, inst[31:20]};
      rv_pkg::imm_u: imm = {inst[31:12], 12'b0};
      rv_pkg::imm_j: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:       imm = '0;
    endcase
  end

  assign is_arith = (opcode == rv_pkg::op_imm) || (opcode == rv_pkg::op_reg);
  assign is_illegal = !op_hit || (is_arith && !f3_hit);

  // any system encoding stops the core
  assign is_ebreak = (opcode == rv_pkg::op_system);
  assign is_jal = (opcode == rv_pkg::op_jal);

  always_comb begin
    if (opcode == rv_pkg::op_lui) begin
      alu_op = rv_pkg::alu_passb;
    end else if (opcode == rv_pkg::op_reg && funct3 == rv_pkg::f3_add &&
                 funct7 == rv_pkg::funct7_sub) begin
      alu_op = rv_pkg::alu_sub;
    end else if (is_arith) begin
      alu_op = f3_op;
    end else begin
      alu_op = rv_pkg::alu_add;
    end
  end

  assign wb_sel = is_jal ? rv_pkg::wb_pc4 : rv_pkg::wb_alu;
  assign src_a_pc = (opcode == rv_pkg::op_auipc);
  assign src_b_imm = (imm_sel == rv_pkg::imm_i) || (imm_sel == rv_pkg::imm_u);
  assign reg_we = !is_illegal && !is_ebreak;

endmodule

//--- rtl/reg_file.sv
// 32 x xlen registers, two async reads, one write; rst clears every entry
module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      we,
  input  logic [rv_pkg::reg_aw-1:0] waddr,
  input  logic [rv_pkg::xlen-1:0]   wdata,
  input  logic [rv_pkg::reg_aw-1:0] raddr1,
  input  logic [rv_pkg::reg_aw-1:0] raddr2,
  output logic [rv_pkg::xlen-1:0]   rdata1,
  output logic [rv_pkg::xlen-1:0]   rdata2,
  output logic [rv_pkg::xlen-1:0]   a0
);

  logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_aw];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**rv_pkg::reg_aw; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  // x10 for the halt code
  assign a0 = regs[10];

endmodule

//--- rtl/alu_exec.sv
// alu and write-back; the write port is combinational, retire and halt are registered
module alu_exec (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [rv_pkg::xlen-1:0]   pc,
  input  logic [rv_pkg::xlen-1:0]   imm,
  input  logic [rv_pkg::xlen-1:0]   rs1_data,
  input  logic [rv_pkg::xlen-1:0]   rs2_data,
  input  logic [rv_pkg::xlen-1:0]   a0,
  input  rv_pkg::alu_op_t           alu_op,
  input  rv_pkg::wb_sel_t           wb_sel,
  input  logic                      src_a_pc,
  input  logic                      src_b_imm,
  input  logic                      reg_we,
  input  logic                      is_ebreak,
  input  logic                      is_illegal,
  input  logic [rv_pkg::reg_aw-1:0] rd,
  output logic                      wb_en,
  output logic [rv_pkg::reg_aw-1:0] wb_addr,
  output logic [rv_pkg::xlen-1:0]   wb_data,
  output logic                      retire_valid,
  output logic [rv_pkg::reg_aw-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]   retire_data,
  output logic                      halt,
  output logic                      halt_illegal,
  output logic [rv_pkg::xlen-1:0]   halt_code
);

  logic [rv_pkg::xlen-1:0] src_a;
  logic [rv_pkg::xlen-1:0] src_b;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic                    halting;

  assign src_a = src_a_pc ? pc : rs1_data;
  assign src_b = src_b_imm ? imm : rs2_data;

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:   alu_result = src_a + src_b;
      rv_pkg::alu_sub:   alu_result = src_a - src_b;
      rv_pkg::alu_slt:   alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
      rv_pkg::alu_xor:   alu_result = src_a ^ src_b;
      rv_pkg::alu_or:    alu_result = src_a | src_b;
      rv_pkg::alu_and:   alu_result = src_a & src_b;
      rv_pkg::alu_passb: alu_result = src_b;
      default:           alu_result = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write-back, lands at the next edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign wb_en = reg_we && !halt && (rd != '0);
  assign wb_addr = rd;
  assign wb_data = (wb_sel == rv_pkg::wb_pc4) ? pc + 32'd4 : alu_result;

  assign halting = !halt && (is_ebreak || is_illegal);

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
      halt <= 1'b0;
      halt_illegal <= 1'b0;
      halt_code <= '0;
    end else begin
      retire_valid <= wb_en;
      // sticky until reset
      if (halting) begin
        halt <= 1'b1;
        halt_illegal <= is_illegal;
        halt_code <= a0;
      end
    end
  end

  always_ff @(posedge clk) begin
    retire_rd <= wb_addr;
    retire_data <= wb_data;
  end

endmodule

//--- rtl/rv_core.sv
// single-cycle rv32i subset; instruction memory must answer in the same cycle, no back-pressure
module rv_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [rv_pkg::xlen-1:0]   inst,
  output logic [rv_pkg::xlen-1:0]   pc,
  output logic                      retire_valid,
  output logic [rv_pkg::reg_aw-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]   retire_data,
  output logic                      halt,
  output logic                      halt_illegal,
  output logic [rv_pkg::xlen-1:0]   halt_code
);

  logic [rv_pkg::reg_aw-1:0] rs1;
  logic [rv_pkg::reg_aw-1:0] rs2;
  logic [rv_pkg::reg_aw-1:0] rd;
  logic [rv_pkg::xlen-1:0]   imm;
  rv_pkg::alu_op_t           alu_op;
  rv_pkg::wb_sel_t           wb_sel;
  logic                      src_a_pc;
  logic                      src_b_imm;
  logic                      reg_we;
  logic                      is_jal;
  logic                      is_ebreak;
  logic                      is_illegal;

  logic [rv_pkg::xlen-1:0]   rs1_data;
  logic [rv_pkg::xlen-1:0]   rs2_data;
  logic [rv_pkg::xlen-1:0]   a0;
  logic                      wb_en;
  logic [rv_pkg::reg_aw-1:0] wb_addr;
  logic [rv_pkg::xlen-1:0]   wb_data;

  pc_fetch pc_fetch_inst (
    .clk   (clk),
    .rst   (rst),
    .imm   (imm),
    .is_jal(is_jal),
    .stop  (is_ebreak | is_illegal),
    .halt  (halt),
    .pc    (pc)
  );

  inst_decode inst_decode_inst (
    .inst      (inst),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .wb_sel    (wb_sel),
    .src_a_pc  (src_a_pc),
    .src_b_imm (src_b_imm),
    .reg_we    (reg_we),
    .is_jal    (is_jal),
    .is_ebreak (is_ebreak),
    .is_illegal(is_illegal)
  );

  reg_file reg_file_inst (
    .clk   (clk),
    .rst   (rst),
    .we    (wb_en),
    .waddr (wb_addr),
    .wdata (wb_data),
    .raddr1(rs1),
    .raddr2(rs2),
    .rdata1(rs1_data),
    .rdata2(rs2_data),
    .a0    (a0)
  );

  alu_exec alu_exec_inst (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .imm         (imm),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .a0          (a0),
    .alu_op      (alu_op),
    .wb_sel      (wb_sel),
    .src_a_pc    (src_a_pc),
    .src_b_imm   (src_b_imm),
    .reg_we      (reg_we),
    .is_ebreak   (is_ebreak),
    .is_illegal  (is_illegal),
    .rd          (rd),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .retire_data (retire_data),
    .halt        (halt),
    .halt_illegal(halt_illegal),
    .halt_code   (halt_code)
  );

endmodule

//--- tb/core_checker.sv
// reference model and compare for rv_core retire and halt outputs; outputs sampled at falling edges
module core_checker #(
  parameter int mem_words = 64
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [rv_pkg::xlen-1:0]   pc,
  input  logic                      retire_valid,
  input  logic [rv_pkg::reg_aw-1:0] retire_rd,
  input  logic [rv_pkg::xlen-1:0]   retire_data,
  input  logic                      halt,
  input  logic                      halt_illegal,
  input  logic [rv_pkg::xlen-1:0]   halt_code,
  input  logic [31:0]               prog [mem_words],
  output int                        pass_count,
  output int                        fail_count
);

  localparam int max_steps = 128;
  localparam int run_limit = 200;
  localparam int quiet_cycles = 5;
  localparam logic [31:0] nop_word = 32'h0000_0013;

  logic [4:0]  exp_rd [max_steps];
  logic [31:0] exp_data [max_steps];
  logic        exp_halted;
  logic        exp_illegal;
  logic [31:0] exp_code;
  logic [31:0] exp_pc;
  int          test_id;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model returning the number of writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic int run_model();
    logic [31:0] regs [32];
    logic [31:0] mpc;
    logic [31:0] idx;
    logic [31:0] w;
    logic [31:0] ia;
    logic [31:0] ib;
    logic [31:0] res;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [4:0]  rd;
    int          n;
    int          steps;
    n = 0;
    steps = 0;
    exp_halted = 1'b0;
    exp_illegal = 1'b0;
    exp_code = '0;
    exp_pc = '0;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    mpc = rv_pkg::pc_reset;
    while (!exp_halted && steps < max_steps) begin
      idx = (mpc - rv_pkg::pc_reset) >> 2;
      w = (idx < mem_words) ? prog[idx] : nop_word;
      op = w[6:0];
      f3 = w[14:12];
      rd = w[11:7];
      ia = regs[w[19:15]];
      ib = (op == rv_pkg::op_imm) ? {{20{w[31]}}, w[31:20]} : regs[w[24:20]];
      res = '0;
      case (op)
        rv_pkg::op_imm, rv_pkg::op_reg: begin
          case (f3)
            rv_pkg::f3_add: begin
              if (op == rv_pkg::op_reg && w[31:25] == rv_pkg::funct7_sub) begin
                res = ia - ib;
              end else begin
                res = ia + ib;
              end
            end
            rv_pkg::f3_slt: res = ($signed(ia) < $signed(ib)) ? 32'd1 : 32'd0;
            rv_pkg::f3_xor: res = ia ^ ib;
            rv_pkg::f3_or:  res = ia | ib;
            rv_pkg::f3_and: res = ia & ib;
            default: begin
              exp_halted = 1'b1;
              exp_illegal = 1'b1;
            end
          endcase
        end
        rv_pkg::op_lui:   res = {w[31:12], 12'b0};
        rv_pkg::op_auipc: res = mpc + {w[31:12], 12'b0};
        rv_pkg::op_jal:   res = mpc + 32'd4;
        rv_pkg::op_system: exp_halted = 1'b1;
        default: begin
          exp_halted = 1'b1;
          exp_illegal = 1'b1;
        end
      endcase
      if (exp_halted) begin
        exp_code = regs[10];
        // pc stays on the halting instruction
        exp_pc = mpc;
      end else begin
        if (rd != 5'd0) begin
          exp_rd[n] = rd;
          exp_data[n] = res;
          regs[rd] = res;
          n++;
        end
        if (op == rv_pkg::op_jal) begin
          mpc = mpc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else begin
          mpc = mpc + 32'd4;
        end
      end
      steps++;
    end
    return n;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare one test
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_test();
    int          exp_count;
    int          got;
    int          errors;
    int          cycles;
    exp_count = run_model();
    got = 0;
    errors = 0;
    cycles = 0;
    if (!exp_halted) begin
      $display("test %0d: reference model never reaches a halt", test_id);
      errors++;
    end
    while (halt !== 1'b1 && cycles < run_limit) begin
      @(negedge clk);
      cycles++;
      if (retire_valid === 1'b1) begin
        if (got >= exp_count) begin
          $display("test %0d: extra retire of x%0d at %0t", test_id, retire_rd, $time);
          errors++;
        end else begin
          if (retire_rd !== exp_rd[got]) begin
            $display("Error at %0t: retire_rd expected %0d, got %0d",
                     $time, exp_rd[got], retire_rd);
            errors++;
          end
          if (retire_data !== exp_data[got]) begin
            $display("Error at %0t: retire_data expected %h, got %h",
                     $time, exp_data[got], retire_data);
            errors++;
          end
        end
        got++;
      end
    end
    if (halt !== 1'b1) begin
      $display("test %0d: core did not halt within %0d cycles", test_id, run_limit);
      errors++;
    end else begin
      if (got < exp_count) begin
        $display("test %0d: missing retires, expected %0d but saw %0d",
                 test_id, exp_count, got);
        errors++;
      end
      if (halt_illegal !== exp_illegal) begin
        $display("Error at %0t: halt_illegal expected %b, got %b",
                 $time, exp_illegal, halt_illegal);
        errors++;
      end
      if (halt_code !== exp_code) begin
        $display("Error at %0t: halt_code expected %h, got %h", $time, exp_code, halt_code);
        errors++;
      end
      repeat (quiet_cycles) begin
        @(negedge clk);
        if (retire_valid !== 1'b0) begin
          $display("test %0d: retire seen after halt at %0t", test_id, $time);
          errors++;
        end
        if (pc !== exp_pc) begin
          $display("Error at %0t: pc expected %h, got %h", $time, exp_pc, pc);
          errors++;
        end
      end
    end
    if (errors == 0) begin
      $display("test %0d passed, %0d writes checked", test_id, exp_count);
      pass_count++;
    end else begin
      $display("test %0d failed with %0d errors", test_id, errors);
      fail_count++;
    end
  endtask

  initial begin
    pass_count = 0;
    fail_count = 0;
    test_id = 0;
    forever begin
      wait (rst === 1'b1);
      wait (rst === 1'b0);
      check_test();
      test_id++;
    end
  end

endmodule

//--- tb/tb_rv_core.sv
// testbench for rv_core; programs start at pc_reset in a 64-word memory, fetches past it return nops
module tb_rv_core;

  localparam int mem_words = 64;
  localparam int num_tests = 6;
  localparam int reset_cycles = 8;
  localparam logic [31:0] nop_word = 32'h0000_0013;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  // twice the program length plus reset and slack for every test
  localparam int watchdog_time = num_tests * (mem_words + reset_cycles + 20) * 10 * 2;

  logic                      clk;
  logic                      rst;
  logic [rv_pkg::xlen-1:0]   inst;
  logic [rv_pkg::xlen-1:0]   pc;
  logic                      retire_valid;
  logic [rv_pkg::reg_aw-1:0] retire_rd;
  logic [rv_pkg::xlen-1:0]   retire_data;
  logic                      halt;
  logic                      halt_illegal;
  logic [rv_pkg::xlen-1:0]   halt_code;

  logic [31:0] imem [mem_words];
  logic [31:0] word_idx;
  int          fill_idx;
  logic [15:0] lfsr_state;
  int          pass_count;
  int          fail_count;

  rv_core rv_core_inst (
    .clk         (clk),
    .rst         (rst),
    .inst        (inst),
    .pc          (pc),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .retire_data (retire_data),
    .halt        (halt),
    .halt_illegal(halt_illegal),
    .halt_code   (halt_code)
  );

  core_checker #(
    .mem_words(mem_words)
  ) core_checker_inst (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .retire_data (retire_data),
    .halt        (halt),
    .halt_illegal(halt_illegal),
    .halt_code   (halt_code),
    .prog        (imem),
    .pass_count  (pass_count),
    .fail_count  (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // same-cycle instruction memory
  assign word_idx = (pc - rv_pkg::pc_reset) >> 2;
  assign inst = ($isunknown(pc) || word_idx >= mem_words) ? nop_word : imem[word_idx];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // encoders and random source
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] imm_inst(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, rv_pkg::op_imm};
  endfunction

  function automatic logic [31:0] reg_inst(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg};
  endfunction

  function automatic logic [31:0] upper_inst(input logic [6:0] op, input logic [4:0] rd,
                                             input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
  endfunction

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
    end
    return bits;
  endfunction

  function automatic logic [2:0] pick_funct3(input logic [2:0] sel);
    case (sel)
      3'd0, 3'd5: return rv_pkg::f3_add;
      3'd1, 3'd6: return rv_pkg::f3_slt;
      3'd2, 3'd7: return rv_pkg::f3_xor;
      3'd3:       return rv_pkg::f3_or;
      default:    return rv_pkg::f3_and;
    endcase
  endfunction

  task automatic put_word(input logic [31:0] word);
    imem[fill_idx] = word;
    fill_idx++;
  endtask

  // 39 random instructions then ebreak at word 39
  task automatic random_program();
    logic [2:0] kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [1:0] hop;
    logic       use_sub;
    for (int i = 0; i < 39; i++) begin
      kind = 3'(rand_bits(3));
      rd = 5'(rand_bits(5));
      rs1 = 5'(rand_bits(5));
      rs2 = 5'(rand_bits(5));
      f3 = pick_funct3(3'(rand_bits(3)));
      hop = 2'(rand_bits(2));
      use_sub = 1'(rand_bits(1));
      case (kind)
        3'd0, 3'd1, 3'd2: put_word(imm_inst(f3, rd, rs1, 12'(rand_bits(12))));
        3'd3, 3'd4: begin
          if (f3 == rv_pkg::f3_add && use_sub) begin
            put_word(reg_inst(rv_pkg::funct7_sub, f3, rd, rs1, rs2));
          end else begin
            put_word(reg_inst(7'b0, f3, rd, rs1, rs2));
          end
        end
        3'd5: put_word(upper_inst(rv_pkg::op_lui, rd, 20'(rand_bits(20))));
        3'd6: put_word(upper_inst(rv_pkg::op_auipc, rd, 20'(rand_bits(20))));
        default: begin
          // forward jump must not pass the ebreak
          if (i + hop + 1 <= 39) begin
            put_word(jal_inst(rd, {17'b0, hop, 2'b00} + 21'd4));
          end else begin
            put_word(imm_inst(f3, rd, rs1, 12'(rand_bits(12))));
          end
        end
      endcase
    end
    put_word(ebreak_word);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test programs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic build_program(input int t);
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = nop_word;
    end
    fill_idx = 0;
    case (t)
      0: begin
        put_word(imm_inst(rv_pkg::f3_add, 5'd10, 5'd0, 12'd5));
        put_word(imm_inst(rv_pkg::f3_add, 5'd1, 5'd0, 12'hffd));
        put_word(reg_inst(7'b0, rv_pkg::f3_add, 5'd2, 5'd1, 5'd10));
        put_word(reg_inst(rv_pkg::funct7_sub, rv_pkg::f3_add, 5'd3, 5'd10, 5'd1));
        put_word(imm_inst(rv_pkg::f3_slt, 5'd4, 5'd1, 12'h000));
        put_word(imm_inst(rv_pkg::f3_xor, 5'd5, 5'd2, 12'h07f));
        put_word(imm_inst(rv_pkg::f3_or, 5'd6, 5'd3, 12'h100));
        put_word(imm_inst(rv_pkg::f3_and, 5'd7, 5'd5, 12'h00f));
        put_word(reg_inst(7'b0, rv_pkg::f3_add, 5'd10, 5'd10, 5'd7));
      end
      1: begin
        put_word(upper_inst(rv_pkg::op_lui, 5'd1, 20'h12345));
        put_word(upper_inst(rv_pkg::op_auipc, 5'd2, 20'h00001));
        put_word(upper_inst(rv_pkg::op_lui, 5'd10, 20'hfffff));
        put_word(upper_inst(rv_pkg::op_auipc, 5'd3, 20'h00000));
      end
      2: begin
        put_word(imm_inst(rv_pkg::f3_add, 5'd10, 5'd0, 12'd1));
        put_word(jal_inst(5'd1, 21'd12));
        put_word(imm_inst(rv_pkg::f3_add, 5'd2, 5'd0, 12'd7));
        put_word(imm_inst(rv_pkg::f3_add, 5'd3, 5'd0, 12'd8));
        put_word(imm_inst(rv_pkg::f3_add, 5'd4, 5'd0, 12'd9));
        put_word(jal_inst(5'd5, 21'd8));
        put_word(imm_inst(rv_pkg::f3_add, 5'd6, 5'd0, 12'd1));
        put_word(reg_inst(7'b0, rv_pkg::f3_add, 5'd10, 5'd10, 5'd1));
        put_word(jal_inst(5'd0, 21'd4));
      end
      3: begin
        put_word(imm_inst(rv_pkg::f3_add, 5'd0, 5'd0, 12'd55));
        put_word(imm_inst(rv_pkg::f3_xor, 5'd0, 5'd0, 12'hfff));
        put_word(imm_inst(rv_pkg::f3_add, 5'd1, 5'd0, 12'd3));
        put_word(reg_inst(7'b0, rv_pkg::f3_add, 5'd2, 5'd0, 5'd0));
        put_word(reg_inst(7'b0, rv_pkg::f3_add, 5'd10, 5'd0, 5'd1));
      end
      4: random_program();
      default: begin
        put_word(imm_inst(rv_pkg::f3_add, 5'd10, 5'd0, 12'd42));
        put_word(imm_inst(rv_pkg::f3_add, 5'd1, 5'd0, 12'd1));
        // load opcode outside the subset
        put_word(32'h0000_2083);
        put_word(imm_inst(rv_pkg::f3_add, 5'd2, 5'd0, 12'd2));
      end
    endcase
    if (t != 4) begin
      put_word(ebreak_word);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst = 1'b1;
    lfsr_state = 16'd24410;
    fill_idx = 0;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = nop_word;
    end
    for (int t = 0; t < num_tests; t++) begin
      @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      build_program(t);
      repeat (reset_cycles) @(posedge clk);
      rst <= 1'b0;
      wait (pass_count + fail_count == t + 1);
    end
    $display("tests finished: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count == num_tests) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_time);
    $display("run timed out at %0t with %0d of %0d tests finished",
             $time, pass_count + fail_count, num_tests);
    $display("Something failed");
    $finish;
  end

endmodule

//--- project.f
rtl/rv_pkg.sv
rtl/key_mux.sv
rtl/pc_fetch.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/alu_exec.sv
rtl/rv_core.sv
tb/core_checker.sv
tb/tb_rv_core.sv
